//--- verilog/posit_pkg.sv
// Posit arithmetic definitions
// Width constants and decoded value structs for 32-bit posits with es = 3
package posit_pkg;

    localparam int NBITS  = 32;   // Posit width
    localparam int ES     = 3;    // Exponent field width
    localparam int SBITS  = 9;    // Signed scale width
    localparam int FBITS  = 26;   // Longest stored fraction
    localparam int FHBITS = 27;   // Fraction with hidden bit
    localparam int MBITS  = 54;   // Exact product of two FHBITS fractions

    // Scales of maxpos and minpos
    localparam int MAXPOS_SCALE = 240;
    localparam int MINPOS_SCALE = -240;

    // Decoded operand, 38 bits
    typedef struct packed {
        logic                    sgn;
        logic signed [SBITS-1:0] scale;      // Regime * 8 + exponent
        logic [FBITS-1:0]        fraction;   // Left aligned, hidden bit dropped
        logic                    inf;        // NaR
        logic                    zero;
    } value;

    // Raw product, 66 bits
    typedef struct packed {
        logic                    sgn;
        logic signed [SBITS-1:0] scale;
        logic [MBITS-1:0]        fraction;   // Hidden bit already shifted out
        logic                    inf;
        logic                    zero;
    } value_product;

endpackage

//--- verilog/posit_decode.sv
// Posit decoder
// Splits a posit into sign, scale, fraction and special flags in one register stage
`timescale 1ns/1ps

module posit_decode
    import posit_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [NBITS-1:0] posit,
    output value             operand,
    output logic             operand_start
);

    logic                    is_zero;
    logic                    is_nar;
    logic [NBITS-1:0]        mag;
    logic [NBITS-2:0]        run_bits;   // Regime run as leading zeros
    logic [5:0]              run;
    logic signed [SBITS-1:0] run_s;
    logic signed [SBITS-1:0] regime;
    logic [NBITS-2:0]        rest;       // Bits after the terminator, left aligned
    logic [ES-1:0]           exponent;
    value                    operand_d;

    function automatic logic [5:0] lead_zeros(input logic [NBITS-2:0] bits);
        lead_zeros = 6'(NBITS - 1);
        for (int i = 0; i < NBITS - 1; i++)
        begin
            if (bits[i])
                lead_zeros = 6'(NBITS - 2 - i);   // Highest set bit wins
        end
    endfunction

    assign is_zero = (posit == '0);
    assign is_nar  = (posit == {1'b1, {(NBITS-1){1'b0}}});
    assign mag     = posit[NBITS-1] ? -posit : posit;

    // A run of ones becomes a run of zeros so one count covers both
    assign run_bits = mag[NBITS-2] ? ~mag[NBITS-2:0] : mag[NBITS-2:0];
    assign run      = lead_zeros(run_bits);
    assign run_s    = SBITS'(run);
    assign regime   = mag[NBITS-2] ? run_s - SBITS'(1) : -run_s;

    assign rest     = mag[NBITS-2:0] << (run + 6'd1);
    assign exponent = rest[NBITS-2 -: ES];   // Reads zero when cut off

    always_comb
    begin
        operand_d      = '0;
        operand_d.zero = is_zero;
        operand_d.inf  = is_nar;
        if (!is_zero && !is_nar)
        begin
            operand_d.sgn      = posit[NBITS-1];
            operand_d.scale    = (regime <<< ES) + SBITS'(exponent);
            operand_d.fraction = rest[NBITS-2-ES -: FBITS];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            operand_start <= 1'b0;
        else
            operand_start <= start;
    end

    always_ff @(posedge clk)
    begin
        operand <= operand_d;
    end

endmodule

//--- verilog/posit_raw_mult.sv
// Raw posit multiplier
// Four register stages from two decoded values to an exact raw product
`timescale 1ns/1ps

module posit_raw_mult
    import posit_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_start,
    input  value         a,
    input  value         b,
    output value_product product,
    output logic         product_start
);

    value                  r0_a;
    value                  r0_b;
    logic                  r0_start;
    logic [FHBITS-1:0]     frac_a;
    logic [FHBITS-1:0]     frac_b;
    logic [MBITS-1:0]      frac_mult;
    logic signed [SBITS:0] scale_sum;   // Sum of two scales needs the extra bit
    logic                  nar;
    value_product          r1_d;
    value_product          r1_product;
    value_product          r2_product;
    logic                  r1_start;
    logic                  r2_start;

    // Stage 0 operand registers
    always_ff @(posedge clk)
    begin
        r0_a <= a;
        r0_b <= b;
    end

    assign frac_a    = {1'b1, r0_a.fraction};   // Hidden bit back
    assign frac_b    = {1'b1, r0_b.fraction};
    assign frac_mult = frac_a * frac_b;

    // Product in [2,4) moves the radix point
    assign scale_sum = r0_a.scale + r0_b.scale + $signed({1'b0, frac_mult[MBITS-1]});
    assign nar       = r0_a.inf | r0_b.inf;

    always_comb
    begin
        r1_d      = '0;
        r1_d.inf  = nar;
        r1_d.zero = (r0_a.zero | r0_b.zero) & ~nar;   // NaR beats zero
        if (!r1_d.inf && !r1_d.zero)
        begin
            r1_d.sgn = r0_a.sgn ^ r0_b.sgn;
            // Clamp just past the posit range so the encoder saturates
            if (scale_sum > MAXPOS_SCALE)
                r1_d.scale = SBITS'(MAXPOS_SCALE + 1);
            else if (scale_sum < MINPOS_SCALE)
                r1_d.scale = SBITS'(MINPOS_SCALE - 1);
            else
                r1_d.scale = scale_sum[SBITS-1:0];
            r1_d.fraction = frac_mult[MBITS-1] ? (frac_mult << 1) : (frac_mult << 2);
        end
    end

    // Stages 1 to 3
    always_ff @(posedge clk)
    begin
        r1_product <= r1_d;
        r2_product <= r1_product;
        product    <= r2_product;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            r0_start      <= 1'b0;
            r1_start      <= 1'b0;
            r2_start      <= 1'b0;
            product_start <= 1'b0;
        end
        else
        begin
            r0_start      <= in_start;
            r1_start      <= r0_start;
            r2_start      <= r1_start;
            product_start <= r2_start;
        end
    end

endmodule

//--- verilog/posit_encode.sv
// Posit encoder
// Rounds a raw product to nearest even and packs it, saturating at maxpos and minpos
`timescale 1ns/1ps

module posit_encode
    import posit_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             in_start,
    input  value_product     product,
    output logic [NBITS-1:0] result,
    output logic             done
);

    logic signed [SBITS-1:0]          regime;      // Scale >>> ES
    logic [4:0]                       shift;       // Extra regime bits beyond the first pair
    logic signed [NBITS+ES+MBITS+1:0] seed;
    logic signed [NBITS+ES+MBITS+1:0] str;         // Regime, exponent, fraction, spare zeros
    logic [NBITS-2:0]                 mag_trunc;
    logic                             guard;
    logic                             sticky;
    logic                             round_up;
    logic [NBITS-2:0]                 mag;
    logic [NBITS-1:0]                 pos;
    logic [NBITS-1:0]                 result_d;

    assign regime = product.scale >>> ES;

    // Negative regime needs -k-1 shifts, which is just ~k
    assign shift = regime[SBITS-1] ? ~regime[4:0] : regime[4:0];

    // 10 grows into a run of ones, 01 into a run of zeros
    assign seed = {regime[SBITS-1] ? 2'b01 : 2'b10,
                   product.scale[ES-1:0],
                   product.fraction,
                   {NBITS{1'b0}}};
    assign str  = seed >>> shift;

    assign mag_trunc = str[NBITS+ES+MBITS+1 -: NBITS-1];
    assign guard     = str[ES+MBITS+2];
    assign sticky    = |str[ES+MBITS+1:0];
    assign round_up  = guard & (sticky | mag_trunc[0]);   // Ties go to even

    always_comb
    begin
        if (product.scale > MAXPOS_SCALE)
            mag = '1;                                   // maxpos
        else if (product.scale < MINPOS_SCALE)
            mag = {{(NBITS-2){1'b0}}, 1'b1};            // minpos
        else
            mag = mag_trunc + {{(NBITS-2){1'b0}}, round_up};
    end

    assign pos = {1'b0, mag};

    always_comb
    begin
        if (product.inf)
            result_d = {1'b1, {(NBITS-1){1'b0}}};
        else if (product.zero)
            result_d = '0;
        else if (product.sgn)
            result_d = -pos;
        else
            result_d = pos;
    end

    always_ff @(posedge clk)
    begin
        result <= result_d;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= in_start;
    end

endmodule

//--- verilog/posit_mult_top.sv
// Posit multiplier top
// Decode, raw multiply and encode, six cycles from start to done
`timescale 1ns/1ps

module posit_mult_top
    import posit_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [NBITS-1:0] in1,
    input  logic [NBITS-1:0] in2,
    output logic [NBITS-1:0] result,
    output logic             done
);

    value         op_a;
    value         op_b;
    logic         op_start;
    value_product raw_product;
    logic         raw_start;

    posit_decode u_dec_a (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .posit         (in1),
        .operand       (op_a),
        .operand_start (op_start)
    );

    // Runs in lockstep with u_dec_a
    posit_decode u_dec_b (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .posit         (in2),
        .operand       (op_b),
        .operand_start ()
    );

    posit_raw_mult u_mult (
        .clk           (clk),
        .reset         (reset),
        .in_start      (op_start),
        .a             (op_a),
        .b             (op_b),
        .product       (raw_product),
        .product_start (raw_start)
    );

    posit_encode u_enc (
        .clk      (clk),
        .reset    (reset),
        .in_start (raw_start),
        .product  (raw_product),
        .result   (result),
        .done     (done)
    );

endmodule

//--- verif/posit_mult_assert.sv
// Posit multiplier assertions
// Strobe latency, reset clearing and zero operand results
`timescale 1ns/1ps

module posit_mult_assert
    import posit_pkg::*;
(
    input logic             clk,
    input logic             reset,
    input logic             start,
    input logic [NBITS-1:0] in1,
    input logic [NBITS-1:0] in2,
    input logic [NBITS-1:0] result,
    input logic             done
);

    localparam logic [NBITS-1:0] NAR_PATTERN = {1'b1, {(NBITS-1){1'b0}}};

    done_after_start: assert property (@(posedge clk) disable iff (reset)
        start |-> ##6 done)
        else $error("done missing six cycles after start");

    // No done without a start six cycles back
    done_has_start: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(start, 6))
        else $error("done without a matching start");

    done_low_after_reset: assert property (@(posedge clk) reset |=> !done)
        else $error("done high in the cycle after reset");

    zero_operand_result: assert property (@(posedge clk) disable iff (reset)
        (start && (in1 == '0 || in2 == '0)) |-> ##6 (result == '0 || result == NAR_PATTERN))
        else $error("zero operand gave a result other than zero or NaR");

endmodule

bind posit_mult_top posit_mult_assert u_assert (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .in1    (in1),
    .in2    (in2),
    .result (result),
    .done   (done)
);

//--- include/posit_model.svh
// Posit reference model
// Real-number decode and nearest-even rounding for 32-bit posits with es = 3
`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

// Positive magnitude string of nbits, MSB first, missing exponent bits read zero
function automatic real posit_mag_real(input logic [31:0] mag, input int nbits);
    int  i;
    int  run;
    int  k;
    int  e;
    real f;
    real w;
    run = 0;
    i = nbits - 1;
    while (i >= 0 && mag[i] == mag[nbits-1])
    begin
        run++;
        i--;
    end
    k = mag[nbits-1] ? run - 1 : -run;
    i--;   // Skip the terminator
    e = 0;
    for (int j = 0; j < 3; j++)
    begin
        e = 2 * e + ((i >= 0) ? int'(mag[i]) : 0);
        i--;
    end
    f = 1.0;
    w = 0.5;
    while (i >= 0)
    begin
        if (mag[i])
            f = f + w;
        w = w / 2.0;
        i--;
    end
    return f * (2.0 ** (8 * k + e));
endfunction

// Zero and NaR both give 0.0 and the caller handles NaR
function automatic real posit_to_real(input logic [31:0] p);
    logic [31:0] mag;
    real         r;
    if (p == 32'h0 || p == 32'h8000_0000)
        return 0.0;
    mag = p[31] ? -p : p;
    r = posit_mag_real({1'b0, mag[30:0]}, 31);
    return p[31] ? -r : r;
endfunction

function automatic logic [31:0] real_to_posit(input real x);
    real         ax;
    real         mid;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] probe;
    logic [31:0] p;
    if (x == 0.0)
        return 32'h0;
    ax = (x < 0.0) ? -x : x;
    lo = 32'h0000_0001;   // minpos
    hi = 32'h7fff_ffff;   // maxpos
    if (ax <= posit_to_real(lo))
        p = lo;
    else if (ax >= posit_to_real(hi))
        p = hi;
    else
    begin
        // Neighbours lo and hi, then the midpoint one bit past lo's last bit
        while (hi - lo > 1)
        begin
            probe = (lo + hi) >> 1;
            if (posit_to_real(probe) <= ax)
                lo = probe;
            else
                hi = probe;
        end
        mid = posit_mag_real({lo[30:0], 1'b1}, 32);
        p = (ax > mid || (ax == mid && lo[0])) ? hi : lo;
    end
    return (x < 0.0) ? -p : p;
endfunction

function automatic logic [31:0] posit_mul_model(input logic [31:0] a, input logic [31:0] b);
    if (a == 32'h8000_0000 || b == 32'h8000_0000)
        return 32'h8000_0000;
    return real_to_posit(posit_to_real(a) * posit_to_real(b));
endfunction

`endif

//--- verif/posit_mult_tb.sv
// Posit multiplier testbench
// Seeded random and directed operands checked against a real-number posit model
`timescale 1ns/1ps

module posit_mult_tb
    import posit_pkg::*;
;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 32'hb4af_a67b;
    localparam int N_SPECIAL    = 8;
    localparam int N_RANDOM     = 2000;
    localparam int N_ROUND      = 300;
    localparam int N_GAP        = 300;
    localparam int MAX_GAP      = 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 10 + N_SPECIAL * 4 + 8 + N_RANDOM
                                  + N_ROUND + N_GAP * (MAX_GAP + 1) + 200;

    localparam logic [31:0] ZERO       = 32'h0000_0000;
    localparam logic [31:0] NAR        = 32'h8000_0000;
    localparam logic [31:0] MAXPOS     = 32'h7fff_ffff;
    localparam logic [31:0] MINPOS     = 32'h0000_0001;
    localparam logic [31:0] NEG_MAXPOS = 32'h8000_0001;
    localparam logic [31:0] NEG_MINPOS = 32'hffff_ffff;
    localparam logic [31:0] NEG_ONE    = 32'hc000_0000;

    logic             clk = 1'b0;
    logic             reset;
    logic             start;
    logic [NBITS-1:0] in1;
    logic [NBITS-1:0] in2;
    logic [NBITS-1:0] result;
    logic             done;
    logic [31:0]      expected[$];   // Products still in the pipeline
    logic [31:0]      x;
    logic [31:0]      y;

    `include "posit_model.svh"

    posit_mult_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .in1    (in1),
        .in2    (in2),
        .result (result),
        .done   (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    // Drives one operation on the falling edge and records its product
    task automatic issue_expect(input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] want);
        @(negedge clk);
        start = 1'b1;
        in1   = a;
        in2   = b;
        expected.push_back(want);
    endtask

    task automatic issue(input logic [31:0] a, input logic [31:0] b);
        issue_expect(a, b, posit_mul_model(a, b));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            start = 1'b0;
            in1   = $urandom;   // Junk operands while idle
            in2   = $urandom;
        end
    endtask

    task automatic drain();
        idle(1);
        while (expected.size() != 0)
            @(negedge clk);
    endtask

    // Few fraction bits and large regimes put products on and near ties
    function automatic logic [31:0] short_fraction_posit(input bit negative_scale);
        int  sc;
        real v;
        sc = 56 + int'($urandom % 32);
        v  = (1.0 + real'($urandom % 16) / 16.0) * (2.0 ** (negative_scale ? -sc : sc));
        if ($urandom % 2)
            v = -v;
        return real_to_posit(v);
    endfunction

    always @(negedge clk)
    begin
        if (done === 1'b1)
        begin
            if (expected.size() == 0)
                fail_run("done went high with no operation pending");
            else
                check_value("result", result, expected.pop_front());
        end
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run("watchdog timeout: the run did not finish in time");
    end

    initial
    begin
        bit neg;
        reset     = 1'b1;
        start     = 1'b0;
        in1       = '0;
        in2       = '0;
        void'($urandom(SEED));

        // A start inside reset must be dropped
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(negedge clk);
            check_value("done", {31'b0, done}, 32'h0);
            start = (i == 2);
            in1   = $urandom;
            in2   = $urandom;
        end
        reset = 1'b0;
        start = 1'b0;
        idle(10);

        for (int i = 0; i < N_SPECIAL; i++)
        begin
            x = (i == 0) ? ZERO : $urandom;
            if (x == NAR)
                x = 32'h4000_0000;
            issue_expect(ZERO, x, ZERO);
            issue_expect(x, ZERO, ZERO);
            y = (i == 1) ? ZERO : (i == 2) ? NAR : $urandom;
            issue_expect(NAR, y, NAR);
            issue_expect(y, NAR, NAR);
        end
        drain();

        for (int i = 0; i < N_RANDOM; i++)
            issue($urandom, $urandom);
        drain();

        issue_expect(MAXPOS, MAXPOS, MAXPOS);
        issue_expect(MINPOS, MINPOS, MINPOS);
        issue_expect(NEG_ONE, MAXPOS, NEG_MAXPOS);
        issue_expect(MAXPOS, NEG_MAXPOS, NEG_MAXPOS);
        issue_expect(NEG_MINPOS, MINPOS, NEG_MINPOS);
        drain();

        for (int i = 0; i < N_ROUND; i++)
        begin
            neg = $urandom % 2;   // Both operands on the same side of one
            issue(short_fraction_posit(neg), short_fraction_posit(neg));
        end
        drain();

        for (int i = 0; i < N_GAP; i++)
        begin
            issue($urandom, $urandom);
            idle(int'($urandom % (MAX_GAP + 1)));
        end
        drain();
        idle(10);

        if (expected.size() != 0)
            fail_run("operations still pending at the end of the run");
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+include
verilog/posit_pkg.sv
verilog/posit_decode.sv
verilog/posit_raw_mult.sv
verilog/posit_encode.sv
verilog/posit_mult_top.sv
verif/posit_mult_assert.sv
verif/posit_mult_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the posit multiplier testbench with Verilator and runs it
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module posit_mult_tb -f sim.f \
    -o posit_mult_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/posit_mult_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0
